// ==== src/wm_program_pkg.sv ====
`default_nettype none

package wm_program_pkg;

    // Wash programs as selected on the front panel
    typedef enum logic [2:0] {
        cotton     = 3'd0,
        synthetics = 3'd1,
        drum_clean = 3'd2,  // Empty drum
        quick_wash = 3'd3,
        daily_wash = 3'd4,
        delicates  = 3'd5,
        wool       = 3'd6,
        colours    = 3'd7
    } wash_mode_t;

    typedef logic [6:0] temp_t;       // Degrees, same scale as the ADC
    typedef logic [3:0] spin_code_t;  // Hundreds of rpm
    typedef logic [3:0] base_time_t;  // Program length in time units

    // Target water temperature per program
    function automatic temp_t mode_temp(input wash_mode_t mode);
        case (mode)
            drum_clean: return 7'd60;
            quick_wash: return 7'd10;
            delicates:  return 7'd30;
            default:    return 7'd40;
        endcase
    endfunction

    // Final spin speed per program
    function automatic spin_code_t mode_spin(input wash_mode_t mode);
        case (mode)
            drum_clean:       return 4'd12;
            quick_wash, wool: return 4'd8;
            delicates:        return 4'd4;
            default:          return 4'd14;
        endcase
    endfunction

    function automatic base_time_t mode_time(input wash_mode_t mode);
        case (mode)
            cotton:     return 4'd10;
            synthetics: return 4'd15;
            drum_clean: return 4'd12;
            quick_wash: return 4'd5;
            daily_wash: return 4'd8;
            delicates:  return 4'd6;
            wool:       return 4'd7;
            default:    return 4'd9;  // Colours
        endcase
    endfunction

endpackage

`default_nettype wire

// ==== src/wm_ctrl_pkg.sv ====
`default_nettype none

package wm_ctrl_pkg;

    typedef logic [9:0] level_t;  // Raw water level sensor reading

    localparam level_t fill_level = 10'd100;  // Drum counts as full at or above this

    // Fixed drum speeds outside the final spin
    localparam logic [3:0] drum_wash  = 4'd3;
    localparam logic [3:0] drum_rinse = 4'd1;

    // Cycle sequencer states
    typedef enum logic [3:0] {
        st_idle         = 4'b0000,
        st_start        = 4'b0001,
        st_fill         = 4'b0010,
        st_heat_fill    = 4'b0011,
        st_wash         = 4'b0100,
        st_drain_wash   = 4'b0101,
        st_rinse        = 4'b0111,
        st_drain_rinse  = 4'b1000,
        st_dry_spin     = 4'b1001,
        st_complete     = 4'b1010,
        st_pause        = 4'b1011,
        st_cancel_drain = 4'b1101   // Stop requested, empty the drum
    } seq_state_t;

endpackage

`default_nettype wire

// ==== src/wm_phase_timer.sv ====
`timescale 1ns/10ps
`default_nettype none

module wm_phase_timer #(
    parameter logic [15:0] ticks_per_unit = 16'd50000
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       phase_run,
    input  wire logic                       phase_clear,
    input  wire wm_program_pkg::base_time_t phase_units,
    output logic                            phase_done
);

    import wm_program_pkg::*;

    logic [15:0] tick_cnt;  // Prescaler within one unit
    base_time_t  unit_cnt;  // Whole units elapsed
    logic        at_end;

    // Total count equals phase_units * ticks_per_unit
    assign at_end     = (unit_cnt == phase_units) && (tick_cnt == 16'd0);
    assign phase_done = phase_run && at_end;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tick_cnt <= '0;
            unit_cnt <= '0;
        end else if (phase_clear) begin
            tick_cnt <= '0;
            unit_cnt <= '0;
        end else if (phase_run && !at_end) begin
            if (tick_cnt == ticks_per_unit - 16'd1) begin
                tick_cnt <= '0;
                unit_cnt <= unit_cnt + 4'd1;
            end else begin
                tick_cnt <= tick_cnt + 16'd1;
            end
        end
        // Neither run nor clear means paused, count holds
    end

endmodule

`default_nettype wire

// ==== src/wm_flow_monitor.sv ====
`timescale 1ns/10ps
`default_nettype none

module wm_flow_monitor #(
    parameter logic [15:0] flow_timeout = 16'd1000
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   flow_watch,
    input  wire logic                   flow_fill,  // 1 while filling, 0 while draining
    input  wire wm_ctrl_pkg::level_t    water_level_sensor,
    output logic                        flow_error
);

    import wm_ctrl_pkg::*;

    level_t      last_level;  // Level seen one cycle earlier
    logic [15:0] stall_cnt;   // Cycles without progress
    logic        moving;

    // Progress means the level moved the expected way since last cycle
    always_comb begin
        if (flow_fill) begin
            moving = water_level_sensor > last_level;
        end else begin
            moving = water_level_sensor < last_level;
        end
    end

    assign flow_error = flow_watch && (stall_cnt == flow_timeout);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            last_level <= '0;
            stall_cnt  <= '0;
        end else begin
            last_level <= water_level_sensor;
            if (!flow_watch) begin
                stall_cnt <= '0;
            end else if (moving) begin
                stall_cnt <= '0;                  // Water is flowing, restart
            end else if (stall_cnt != flow_timeout) begin
                stall_cnt <= stall_cnt + 16'd1;   // Saturates at the timeout
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/wm_fault_supervisor.sv ====
`timescale 1ns/10ps
`default_nettype none

module wm_fault_supervisor (
    input  wire logic clk,
    input  wire logic reset,
    input  wire logic pause,
    input  wire logic continue_signal,
    input  wire logic vibration_sensor,
    input  wire logic flow_error,
    input  wire logic flow_fill,
    output logic      pause_pulse,
    output logic      continue_pulse,
    output logic      fault_active,
    output logic      water_flow_error_led,
    output logic      drainage_error_led,
    output logic      vibration_error_led
);

    logic pause_d;
    logic continue_d;
    logic fill_flag;   // Fill stalled
    logic drain_flag;  // Drain stalled
    logic vib_flag;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pause_d        <= 1'b0;
            continue_d     <= 1'b0;
            pause_pulse    <= 1'b0;
            continue_pulse <= 1'b0;
        end else begin
            pause_d        <= pause;
            continue_d     <= continue_signal;
            pause_pulse    <= pause && !pause_d;               // Rising edges only
            continue_pulse <= continue_signal && !continue_d;
        end
    end

    // A new fault wins over a clearing continue in the same cycle
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fill_flag  <= 1'b0;
            drain_flag <= 1'b0;
            vib_flag   <= 1'b0;
        end else begin
            if (vibration_sensor) begin
                vib_flag <= 1'b1;
            end else if (continue_pulse) begin
                vib_flag <= 1'b0;
            end

            if (flow_error && flow_fill) begin
                fill_flag <= 1'b1;
            end else if (continue_pulse) begin
                fill_flag <= 1'b0;
            end

            if (flow_error && !flow_fill) begin
                drain_flag <= 1'b1;
            end else if (continue_pulse) begin
                drain_flag <= 1'b0;
            end
        end
    end

    assign fault_active         = fill_flag || drain_flag || vib_flag;
    assign water_flow_error_led = fill_flag;
    assign drainage_error_led   = drain_flag;
    assign vibration_error_led  = vib_flag;

endmodule

`default_nettype wire

// ==== src/wm_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module wm_sequencer (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       start,
    input  wire logic                       stop,
    input  wire logic                       door_locked,
    input  wire wm_program_pkg::wash_mode_t wash_mode,
    input  wire wm_program_pkg::temp_t      temperature_adc_sensor,
    input  wire wm_ctrl_pkg::level_t        water_level_sensor,
    input  wire logic                       pause_pulse,
    input  wire logic                       continue_pulse,
    input  wire logic                       fault_active,
    input  wire logic                       phase_done,
    output logic                            phase_run,
    output logic                            phase_clear,
    output wm_program_pkg::base_time_t      phase_units,
    output logic                            flow_watch,
    output logic                            flow_fill,
    output logic                            door_lock,
    output logic                            water_valve,
    output logic                            heater,
    output logic                            drain_pump,
    output wm_program_pkg::spin_code_t      drum_motor,
    output logic                            cycle_complete_led
);

    import wm_program_pkg::*;
    import wm_ctrl_pkg::*;

    seq_state_t state;
    seq_state_t next_state;
    seq_state_t resume_state;  // Where continue returns to
    wash_mode_t mode_q;        // Program chosen at start
    temp_t      target_temp;
    spin_code_t spin_speed;
    base_time_t base_time;
    logic       running;       // Pause and faults only act here
    logic       full;
    logic       empty;
    logic       cold;

    assign target_temp = mode_temp(mode_q);
    assign spin_speed  = mode_spin(mode_q);
    assign base_time   = mode_time(mode_q);

    assign full    = water_level_sensor >= fill_level;
    assign empty   = water_level_sensor == '0;
    assign cold    = temperature_adc_sensor < target_temp;
    assign running = !(state inside {st_idle, st_pause, st_cancel_drain});

    always_comb begin
        next_state = state;
        if (stop) begin
            next_state = st_cancel_drain;
        end else if (state == st_pause && continue_pulse) begin
            next_state = resume_state;
        end else if (running && fault_active) begin
            next_state = st_pause;
        end else if (running && pause_pulse) begin
            next_state = st_pause;
        end else begin
            case (state)
                st_idle:         if (start && door_locked) next_state = st_start;
                st_start:        next_state = st_fill;
                st_fill:         if (full) next_state = st_heat_fill;
                st_heat_fill:    if (full && !cold) next_state = st_wash;
                st_wash:         if (phase_done) next_state = st_drain_wash;
                st_drain_wash:   if (empty) next_state = st_rinse;
                st_rinse:        if (phase_done) next_state = st_drain_rinse;
                st_drain_rinse:  if (empty) next_state = st_dry_spin;
                st_dry_spin:     if (phase_done) next_state = st_complete;
                st_complete:     next_state = st_idle;
                st_pause:        next_state = st_pause;   // Wait for continue
                st_cancel_drain: if (empty) next_state = st_idle;
                default:         next_state = st_cancel_drain;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state        <= st_idle;
            resume_state <= st_idle;
            mode_q       <= cotton;
        end else begin
            state <= next_state;
            if (next_state == st_pause && state != st_pause) begin
                resume_state <= state;
            end
            if (state == st_idle && next_state == st_start) begin
                mode_q <= wash_mode;  // Program fixed for the whole cycle
            end
        end
    end

    // Actuators and timer control follow the state directly
    always_comb begin
        door_lock          = state != st_idle;
        water_valve        = 1'b0;
        heater             = 1'b0;
        drain_pump         = 1'b0;
        drum_motor         = '0;
        cycle_complete_led = 1'b0;
        phase_run          = 1'b0;
        phase_clear        = 1'b1;
        phase_units        = '0;
        case (state)
            st_fill: water_valve = 1'b1;
            st_heat_fill: begin
                water_valve = !full;  // Top up while heating
                heater      = cold;
            end
            st_wash: begin
                heater      = cold;
                drum_motor  = drum_wash;
                phase_run   = 1'b1;
                phase_clear = 1'b0;
                phase_units = base_time >> 1;
            end
            st_rinse: begin
                drum_motor  = drum_rinse;
                phase_run   = 1'b1;
                phase_clear = 1'b0;
                phase_units = base_time / 4'd5;
            end
            st_dry_spin: begin
                drum_motor  = spin_speed;
                phase_run   = 1'b1;
                phase_clear = 1'b0;
                phase_units = base_time / 4'd5;
            end
            st_drain_wash, st_drain_rinse, st_cancel_drain: drain_pump = !empty;
            st_complete: cycle_complete_led = 1'b1;
            st_pause:    phase_clear = 1'b0;  // Keep the phase count
            default: ;
        endcase
    end

    // Watch the water only while it is supposed to move
    assign flow_fill  = water_valve;
    assign flow_watch = water_valve || drain_pump;

endmodule

`default_nettype wire

// ==== src/washing_machine.sv ====
`timescale 1ns/10ps
`default_nettype none

module washing_machine #(
    parameter logic [15:0] ticks_per_unit = 16'd50000,
    parameter logic [15:0] flow_timeout   = 16'd1000
) (
    input  wire logic                       clk,
    input  wire logic                       reset,
    input  wire logic                       start,
    input  wire logic                       stop,
    input  wire logic                       pause,
    input  wire logic                       continue_signal,
    input  wire logic                       door_locked,       // 1 when the door is shut
    input  wire logic                       vibration_sensor,  // 1 on excessive vibration
    input  wire wm_program_pkg::temp_t      temperature_adc_sensor,
    input  wire wm_program_pkg::wash_mode_t wash_mode,
    input  wire wm_ctrl_pkg::level_t        water_level_sensor,
    output logic                            cycle_complete_led,
    output logic                            door_lock,
    output logic                            water_valve,
    output logic                            heater,
    output logic                            drain_pump,
    output wm_program_pkg::spin_code_t      drum_motor,
    output logic                            water_flow_error_led,
    output logic                            drainage_error_led,
    output logic                            vibration_error_led
);

    import wm_program_pkg::*;

    logic       phase_run;
    logic       phase_clear;
    base_time_t phase_units;
    logic       phase_done;
    logic       flow_watch;
    logic       flow_fill;
    logic       flow_error;
    logic       pause_pulse;
    logic       continue_pulse;
    logic       fault_active;

    wm_sequencer u_sequencer (
        .clk                    (clk),
        .reset                  (reset),
        .start                  (start),
        .stop                   (stop),
        .door_locked            (door_locked),
        .wash_mode              (wash_mode),
        .temperature_adc_sensor (temperature_adc_sensor),
        .water_level_sensor     (water_level_sensor),
        .pause_pulse            (pause_pulse),
        .continue_pulse         (continue_pulse),
        .fault_active           (fault_active),
        .phase_done             (phase_done),
        .phase_run              (phase_run),
        .phase_clear            (phase_clear),
        .phase_units            (phase_units),
        .flow_watch             (flow_watch),
        .flow_fill              (flow_fill),
        .door_lock              (door_lock),
        .water_valve            (water_valve),
        .heater                 (heater),
        .drain_pump             (drain_pump),
        .drum_motor             (drum_motor),
        .cycle_complete_led     (cycle_complete_led)
    );

    wm_phase_timer #(
        .ticks_per_unit (ticks_per_unit)
    ) u_phase_timer (
        .clk         (clk),
        .reset       (reset),
        .phase_run   (phase_run),
        .phase_clear (phase_clear),
        .phase_units (phase_units),
        .phase_done  (phase_done)
    );

    wm_flow_monitor #(
        .flow_timeout (flow_timeout)
    ) u_flow_monitor (
        .clk                (clk),
        .reset              (reset),
        .flow_watch         (flow_watch),
        .flow_fill          (flow_fill),
        .water_level_sensor (water_level_sensor),
        .flow_error         (flow_error)
    );

    wm_fault_supervisor u_fault_supervisor (
        .clk                  (clk),
        .reset                (reset),
        .pause                (pause),
        .continue_signal      (continue_signal),
        .vibration_sensor     (vibration_sensor),
        .flow_error           (flow_error),
        .flow_fill            (flow_fill),
        .pause_pulse          (pause_pulse),
        .continue_pulse       (continue_pulse),
        .fault_active         (fault_active),
        .water_flow_error_led (water_flow_error_led),
        .drainage_error_led   (drainage_error_led),
        .vibration_error_led  (vibration_error_led)
    );

endmodule

`default_nettype wire

// ==== verif/wm_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module wm_clock_gen #(
    parameter int half_period = 5,
    parameter int reset_cycles = 3
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(half_period) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;  // Released on an edge like the other inputs
    end

endmodule

`default_nettype wire

// ==== verif/wm_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

module wm_washing_checker #(
    parameter logic [15:0] flow_timeout = 16'd1000
) (
    input wire logic       clk,
    input wire logic       reset,
    input wire logic       start,
    input wire logic       stop,
    input wire logic       pause,
    input wire logic       continue_signal,
    input wire logic       door_locked,
    input wire logic       vibration_sensor,
    input wire logic [6:0] temperature_adc_sensor,
    input wire logic [2:0] wash_mode,
    input wire logic [9:0] water_level_sensor,
    input wire logic       door_lock,
    input wire logic       water_valve,
    input wire logic       heater,
    input wire logic       drain_pump,
    input wire logic [3:0] drum_motor,
    input wire logic       water_flow_error_led,
    input wire logic       drainage_error_led,
    input wire logic       vibration_error_led,
    input wire logic       cycle_complete_led
);

    logic        failed = 1'b0;  // Read by the testbench top
    logic [2:0]  cur_mode;
    logic [7:0]  wash_cycles;    // Wash cycles of the running program, pauses included
    logic        wash_q;
    logic        pause_q;
    logic        pause_hit_q;
    logic        pause_hit_qq;
    logic        cont_q;
    logic        cont_rise;
    logic        cont_rise_q;
    logic        cont_clear_q;
    logic        cont_clear_qq;
    logic        cancelling;
    logic [9:0]  prev_level;
    logic [15:0] fill_wait;
    logic [15:0] drain_wait;

    // Program table: cotton, synthetics, drum clean, quick, daily, delicates, wool, colours
    function automatic logic [6:0] exp_temp(input logic [2:0] m);
        case (m)
            3'd2:    return 7'd60;
            3'd3:    return 7'd10;
            3'd5:    return 7'd30;
            default: return 7'd40;
        endcase
    endfunction

    function automatic logic [3:0] exp_spin(input logic [2:0] m);
        case (m)
            3'd2:       return 4'd12;
            3'd3, 3'd6: return 4'd8;
            3'd5:       return 4'd4;
            default:    return 4'd14;
        endcase
    endfunction

    function automatic int exp_wash_len(input logic [2:0] m);
        int base;
        case (m)
            3'd0:    base = 10;
            3'd1:    base = 15;
            3'd2:    base = 12;
            3'd3:    base = 5;
            3'd4:    base = 8;
            3'd5:    base = 6;
            3'd6:    base = 7;
            default: base = 9;
        endcase
        return (base / 2) * 4 + 1;
    endfunction

    assign cont_rise = continue_signal && !cont_q;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cur_mode      <= 3'd0;
            wash_cycles   <= '0;
            wash_q        <= 1'b0;
            pause_q       <= 1'b0;
            pause_hit_q   <= 1'b0;
            pause_hit_qq  <= 1'b0;
            cont_q        <= 1'b0;
            cont_rise_q   <= 1'b0;
            cont_clear_q  <= 1'b0;
            cont_clear_qq <= 1'b0;
            cancelling    <= 1'b0;
            prev_level    <= '0;
            fill_wait     <= '0;
            drain_wait    <= '0;
        end else begin
            if (!door_lock && start && door_locked && !stop) begin
                cur_mode <= wash_mode;
            end
            if (!door_lock) begin
                wash_cycles <= '0;
            end else if (drum_motor == 4'd3) begin
                wash_cycles <= wash_cycles + 8'd1;
            end
            wash_q        <= drum_motor == 4'd3;
            pause_q       <= pause;
            pause_hit_q   <= pause && !pause_q && drum_motor == 4'd3 && !stop;
            pause_hit_qq  <= pause_hit_q;
            cont_q        <= continue_signal;
            cont_rise_q   <= cont_rise;
            cont_clear_q  <= cont_rise && !vibration_sensor;
            cont_clear_qq <= cont_clear_q;
            if (stop) begin
                cancelling <= 1'b1;
            end else if (!door_lock) begin
                cancelling <= 1'b0;
            end
            prev_level <= water_level_sensor;
            // Cycles since the water last moved the expected way
            if (water_flow_error_led || water_level_sensor > prev_level) begin
                fill_wait <= '0;
            end else if (water_valve || fill_wait != 0) begin
                fill_wait <= fill_wait + 16'd1;
            end
            if (drainage_error_led || water_level_sensor < prev_level) begin
                drain_wait <= '0;
            end else if (drain_pump || drain_wait != 0) begin
                drain_wait <= drain_wait + 16'd1;
            end
        end
    end

    spin_speed: assert property (@(posedge clk) disable iff (reset)
        (drum_motor != 4'd0 && drum_motor != 4'd3 && drum_motor != 4'd1)
        |-> drum_motor == exp_spin(cur_mode))
        else begin failed = 1'b1; $error("spin speed differs from program"); end

    wash_length: assert property (@(posedge clk) disable iff (reset)
        (wash_q && drain_pump) |-> int'(wash_cycles) == exp_wash_len(cur_mode))
        else begin failed = 1'b1; $error("wash phase length wrong"); end

    heater_limit: assert property (@(posedge clk) disable iff (reset)
        heater |-> temperature_adc_sensor < exp_temp(cur_mode))
        else begin failed = 1'b1; $error("heater on at target temperature"); end

    complete_pulse: assert property (@(posedge clk) disable iff (reset)
        cycle_complete_led |=> (!cycle_complete_led && !door_lock))
        else begin failed = 1'b1; $error("cycle complete LED not a single pulse"); end

    door_interlock: assert property (@(posedge clk) disable iff (reset)
        !door_lock |-> (!water_valve && !heater && !drain_pump && drum_motor == 4'd0))
        else begin failed = 1'b1; $error("actuator on with door unlocked"); end

    door_open_start: assert property (@(posedge clk) disable iff (reset)
        (!door_lock && !door_locked && !stop) |=> !door_lock)
        else begin failed = 1'b1; $error("cycle started with door open"); end

    pause_wash: assert property (@(posedge clk) disable iff (reset)
        pause_hit_qq |-> (!water_valve && !heater && drum_motor == 4'd0 && door_lock))
        else begin failed = 1'b1; $error("pause did not stop the drum"); end

    vib_set: assert property (@(posedge clk) disable iff (reset)
        vibration_sensor |=> vibration_error_led)
        else begin failed = 1'b1; $error("vibration fault not latched"); end

    vib_hold: assert property (@(posedge clk) disable iff (reset)
        (vibration_error_led && !cont_rise && !cont_rise_q) |=> vibration_error_led)
        else begin failed = 1'b1; $error("vibration LED dropped early"); end

    vib_clear: assert property (@(posedge clk) disable iff (reset)
        cont_clear_qq |-> !vibration_error_led)
        else begin failed = 1'b1; $error("vibration LED not cleared"); end

    fill_stall: assert property (@(posedge clk) disable iff (reset)
        fill_wait <= flow_timeout + 16'd3)
        else begin failed = 1'b1; $error("fill stall not flagged in time"); end

    drain_stall: assert property (@(posedge clk) disable iff (reset)
        drain_wait <= flow_timeout + 16'd3)
        else begin failed = 1'b1; $error("drain stall not flagged in time"); end

    stop_drain: assert property (@(posedge clk) disable iff (reset)
        (stop && water_level_sensor != 10'd0)
        |=> (drain_pump && !water_valve && !heater && drum_motor == 4'd0))
        else begin failed = 1'b1; $error("stop did not start the drain"); end

    stop_unlock: assert property (@(posedge clk) disable iff (reset)
        (cancelling && water_level_sensor == 10'd0 && !stop) |=> !door_lock)
        else begin failed = 1'b1; $error("door stayed locked after cancel"); end

endmodule

bind washing_machine wm_washing_checker #(.flow_timeout(flow_timeout)) chk (.*);

`default_nettype wire

// ==== verif/tb_washing_machine.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_washing_machine;

    localparam int cycle_len = 20 + 40 + 28 + 20 + 12 + 20 + 12 + 20;  // Fill, heat, phases, drains
    localparam int num_scen  = 9;
    localparam int max_cycles = cycle_len * num_scen * 2;

    logic       clk;
    logic       reset;
    logic       start;
    logic       stop;
    logic       pause;
    logic       continue_signal;
    logic       door_locked;
    logic       vibration_sensor;
    logic [6:0] temperature_adc_sensor;
    logic [2:0] wash_mode;
    logic [9:0] water_level_sensor;
    logic       cycle_complete_led;
    logic       door_lock;
    logic       water_valve;
    logic       heater;
    logic       drain_pump;
    logic [3:0] drum_motor;
    logic       water_flow_error_led;
    logic       drainage_error_led;
    logic       vibration_error_led;
    logic       freeze;       // Plant stops moving water
    logic       cool_req;     // Back to cold water for a new program
    logic [31:0] lfsr = 32'h8489_33b5;
    int          cycle_cnt = 0;
    logic [2:0]  mode;

    wm_clock_gen clk_gen (.clk(clk), .reset(reset));

    washing_machine #(
        .ticks_per_unit (16'd4),
        .flow_timeout   (16'd20)
    ) dut (.*);

    // Plant model of drum water and temperature
    always @(posedge clk) begin
        if (reset) begin
            water_level_sensor     <= '0;
            temperature_adc_sensor <= 7'd20;
        end else begin
            if (!freeze && water_valve && water_level_sensor < 10'd1000)
                water_level_sensor <= water_level_sensor + 10'd5;
            else if (!freeze && drain_pump && water_level_sensor >= 10'd5)
                water_level_sensor <= water_level_sensor - 10'd5;
            if (cool_req)
                temperature_adc_sensor <= 7'd20;
            else if (heater && temperature_adc_sensor < 7'd120)
                temperature_adc_sensor <= temperature_adc_sensor + 7'd1;
        end
    end

    always @(negedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (dut.chk.failed) begin
            $display("MISMATCH at %0t: a checker assertion failed", $time);
            $display("ERRORS FOUND");
            $fatal(1);
        end else if (cycle_cnt > max_cycles) begin
            $display("Timeout: the run went past %0d cycles", max_cycles);
            $display("ERRORS FOUND");
            $fatal(1);
        end
    end

    // One LFSR step per bit taken
    function automatic logic [2:0] next_bits(input int n);
        logic [2:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            bits[i] = lfsr[0];
        end
        return bits;
    endfunction

    function automatic logic seen(input int sel);
        case (sel)
            0:       return cycle_complete_led;
            1:       return drum_motor == 4'd3;
            2:       return water_valve;
            3:       return drain_pump;
            4:       return water_flow_error_led;
            5:       return drainage_error_led;
            default: return !door_lock;
        endcase
    endfunction

    task automatic wait_for(input int sel, input int limit, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (!seen(sel)) begin
            n++;
            if (n > limit) begin
                $display("Timeout: waited %0d cycles for %s", limit, what);
                $display("ERRORS FOUND");
                $fatal(1);
            end
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic start_cycle(input logic [2:0] m);
        door_locked <= 1'b1;
        wash_mode   <= m;
        start       <= 1'b1;
        cool_req    <= 1'b1;
        @(posedge clk);
        start    <= 1'b0;
        cool_req <= 1'b0;
    endtask

    task automatic give_continue();
        continue_signal <= 1'b1;
        @(posedge clk);
        continue_signal <= 1'b0;
    endtask

    initial begin
        start            = 1'b0;
        stop             = 1'b0;
        pause            = 1'b0;
        continue_signal  = 1'b0;
        door_locked      = 1'b0;
        vibration_sensor = 1'b0;
        wash_mode        = '0;
        freeze           = 1'b0;
        cool_req         = 1'b0;
        @(negedge reset);
        @(posedge clk);
        start <= 1'b1;  // Door open, nothing may move
        idle_cycles(5);
        start <= 1'b0;
        for (int i = 0; i < 4; i++) begin
            mode = next_bits(3);
            start_cycle(mode);
            wait_for(0, cycle_len * 2, "cycle complete");
        end
        mode = next_bits(3);
        start_cycle(mode);
        wait_for(1, cycle_len, "wash phase");
        idle_cycles(3);
        pause <= 1'b1;
        idle_cycles(4);
        pause <= 1'b0;
        give_continue();
        wait_for(0, cycle_len * 2, "cycle complete after pause");
        start_cycle(3'd1);
        wait_for(1, cycle_len, "wash phase");
        vibration_sensor <= 1'b1;
        idle_cycles(2);
        vibration_sensor <= 1'b0;
        idle_cycles(5);
        give_continue();
        wait_for(0, cycle_len * 2, "cycle complete after vibration");
        start_cycle(3'd0);
        wait_for(2, 10, "water valve");
        idle_cycles(2);
        freeze <= 1'b1;
        wait_for(4, 40, "fill error LED");
        freeze <= 1'b0;
        give_continue();
        wait_for(0, cycle_len * 2, "cycle complete after fill fault");
        start_cycle(3'd4);
        wait_for(3, cycle_len, "drain pump");
        idle_cycles(2);
        freeze <= 1'b1;
        wait_for(5, 40, "drain error LED");
        freeze <= 1'b0;
        give_continue();
        wait_for(0, cycle_len * 2, "cycle complete after drain fault");
        start_cycle(3'd2);
        wait_for(2, 10, "water valve");
        idle_cycles(12);
        stop <= 1'b1;
        @(posedge clk);
        stop <= 1'b0;
        wait_for(6, cycle_len, "door unlock after stop");
        idle_cycles(3);
        if (dut.chk.failed) begin
            $display("ERRORS FOUND");
            $fatal(1);
        end else begin
            $display("NO ERRORS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
src/wm_program_pkg.sv
src/wm_ctrl_pkg.sv
src/wm_phase_timer.sv
src/wm_flow_monitor.sv
src/wm_fault_supervisor.sv
src/wm_sequencer.sv
src/washing_machine.sv
verif/wm_clock_gen.sv
verif/wm_assert.sv
verif/tb_washing_machine.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top-module tb_washing_machine -o sim_wm

# The simulator exits non-zero on failure, the search below decides the result
out=$(./obj_dir/sim_wm +verilator+error+limit+100 2>&1 || true)
echo "$out"
grep -q "NO ERRORS" <<< "$out"
